// File: src.f
+incdir+common
+incdir+tb
common/eval_pkg.sv
hw/eval_control.sv
evaluate/material_eval.sv
evaluate/occupancy_phase.sv
evaluate/taper_blend.sv
hw/evaluate_top.sv
tb/tb_evaluate.sv

// File: Bender.yml
package:
  name: chess_eval

export_include_dirs:
  - common

sources:
  - files:
      - common/eval_pkg.sv
      - hw/eval_control.sv
      - evaluate/material_eval.sv
      - evaluate/occupancy_phase.sv
      - evaluate/taper_blend.sv
      - hw/evaluate_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_evaluate.sv

// File: tb/eval_model.svh
`ifndef EVAL_MODEL_SVH
`define EVAL_MODEL_SVH

// Reference values straight from the piece table
function automatic int piece_value(input logic [2:0] kind, input logic endgame);
   case (kind)
      3'd1:    piece_value = endgame ? `EG_PAWN : `MG_PAWN;
      3'd2:    piece_value = endgame ? `EG_KNIGHT : `MG_KNIGHT;
      3'd3:    piece_value = endgame ? `EG_BISHOP : `MG_BISHOP;
      3'd4:    piece_value = endgame ? `EG_ROOK : `MG_ROOK;
      3'd5:    piece_value = endgame ? `EG_QUEEN : `MG_QUEEN;
      default: piece_value = 0;               // Empty, king, unused
   endcase
endfunction

function automatic int side_total(input board_t b, input logic black, input logic endgame);
   int         total;
   logic [3:0] code;
   total = 0;
   for (int sq = 0; sq < `SQUARES; sq++)
   begin
      code = b[sq * `PIECE_WIDTH +: `PIECE_WIDTH];
      if (code[3] == black)
         total += piece_value(code[2:0], endgame);
   end
   return total;
endfunction

function automatic int clamped_phase(input board_t b);
   int         count;
   logic [3:0] code;
   count = 0;
   for (int sq = 0; sq < `SQUARES; sq++)
   begin
      code = b[sq * `PIECE_WIDTH +: `PIECE_WIDTH];
      if (code[2:0] != 3'd0 && code[2:0] != 3'd7)
         count++;
   end
   return (count > `PHASE_MAX) ? `PHASE_MAX : count;
endfunction

// Fixed-point divide by 62, truncation toward zero
function automatic int tapered(input int mg, input int eg, input int weight);
   longint blend;
   blend = longint'(mg) * weight + longint'(eg) * (`PHASE_MAX - weight);
   return int'(blend * `PHASE_RECIP / (longint'(1) << `PHASE_SCALE_SHIFT));
endfunction

function automatic int expected_eval(input board_t b);
   return tapered(side_total(b, 1'b0, 1'b0) - side_total(b, 1'b1, 1'b0),
                  side_total(b, 1'b0, 1'b1) - side_total(b, 1'b1, 1'b1),
                  clamped_phase(b));
endfunction

// Phase pinned at the limit, so only the middle-game score counts
function automatic int full_phase_eval(input board_t b);
   return tapered(side_total(b, 1'b0, 1'b0) - side_total(b, 1'b1, 1'b0),
                  side_total(b, 1'b0, 1'b1) - side_total(b, 1'b1, 1'b1),
                  `PHASE_MAX);
endfunction

`endif

// File: tb/tb_evaluate.sv
`default_nettype none

`include "eval_params.svh"

module tb_evaluate;
   import eval_pkg::*;

   localparam int NUM_BOARDS     = 200;
   localparam int NUM_DIRECTED   = 8;            // Boundary boards and held-valid pair
   localparam int TIMEOUT_CYCLES = (NUM_BOARDS + NUM_DIRECTED) * 80;
   localparam int VALID_WINDOW   = 30;           // Cycles from is_attacking_done

   logic      clk;
   logic      reset;
   logic      board_valid;
   board_t    board_in;
   logic      is_attacking_done;
   logic      clear_eval;
   score_t    eval;
   logic      eval_valid;
   material_t material_white;
   material_t material_black;

   integer seed = 32'h8220_9a27;
   int     value_errors = 0;
   int     protocol_errors = 0;
   int     cycle_count = 0;

   `include "eval_model.svh"

   evaluate_top dut_i (
      .clk               (clk),
      .reset             (reset),
      .board_valid       (board_valid),
      .board_in          (board_in),
      .is_attacking_done (is_attacking_done),
      .clear_eval        (clear_eval),
      .eval              (eval),
      .eval_valid        (eval_valid),
      .material_white    (material_white),
      .material_black    (material_black)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Random density per board, both empty codes used
   task automatic make_random_board(output board_t b);
      int empty_pct;
      int r;
      empty_pct = $unsigned($random(seed)) % 101;
      for (int sq = 0; sq < `SQUARES; sq++)
      begin
         r = $random(seed);
         if ($unsigned($random(seed)) % 100 < empty_pct)
            b[sq * `PIECE_WIDTH +: `PIECE_WIDTH] = {r[3], (r[4] ? 3'd7 : 3'd0)};
         else
            b[sq * `PIECE_WIDTH +: `PIECE_WIDTH] = {r[3], 3'(r[15:8] % 6 + 1)};
      end
   endtask

   task automatic check_result(input board_t b, input int exp_eval);
      int exp_white;
      int exp_black;
      exp_white = side_total(b, 1'b0, 1'b0);
      exp_black = side_total(b, 1'b1, 1'b0);
      assert (int'(eval) == exp_eval)
      else
      begin
         value_errors++;
         $display("FAILED at %0t: eval %0d, expected %0d", $time, eval, exp_eval);
      end
      assert (material_white == material_t'(exp_white))
      else
      begin
         value_errors++;
         $display("FAILED at %0t: material_white %0d, expected %0d",
                  $time, material_white, exp_white);
      end
      assert (material_black == material_t'(exp_black))
      else
      begin
         value_errors++;
         $display("FAILED at %0t: material_black %0d, expected %0d",
                  $time, material_black, exp_black);
      end
   endtask

   task automatic wait_for_valid(output logic seen);
      int waited;
      waited = 0;
      do
      begin
         @(posedge clk);
         waited++;
      end
      while (!eval_valid && waited < VALID_WINDOW);
      seen = eval_valid;
      assert (seen)
      else
      begin
         protocol_errors++;
         $display("eval_valid did not rise within %0d cycles of is_attacking_done",
                  VALID_WINDOW);
      end
   endtask

   // Result must sit still until cleared, then drop one cycle later
   task automatic hold_and_clear(input int hold_cycles);
      score_t held;
      held = eval;
      repeat (hold_cycles)
      begin
         @(posedge clk);
         assert (eval_valid)
         else
         begin
            protocol_errors++;
            $display("eval_valid fell before clear_eval was given");
         end
         assert (eval == held)
         else
         begin
            value_errors++;
            $display("FAILED at %0t: eval moved from %0d to %0d while valid", $time, held, eval);
         end
      end
      clear_eval        <= 1'b1;
      is_attacking_done <= 1'b0;
      @(posedge clk);
      clear_eval <= 1'b0;
      @(posedge clk);
      assert (!eval_valid)
      else
      begin
         protocol_errors++;
         $display("eval_valid stayed high after clear_eval");
      end
   endtask

   task automatic run_board(input board_t b, input int withhold, input int exp_eval);
      board_t other;
      logic   seen;
      make_random_board(other);
      @(posedge clk);
      board_in    <= b;
      board_valid <= 1'b1;
      @(posedge clk);
      board_valid <= 1'b0;
      board_in    <= other;                   // Only the edge board may be used
      repeat (withhold)
      begin
         @(posedge clk);
         assert (!eval_valid)
         else
         begin
            protocol_errors++;
            $display("eval_valid rose while is_attacking_done was withheld");
         end
      end
      is_attacking_done <= 1'b1;
      wait_for_valid(seen);
      if (seen)
      begin
         check_result(b, exp_eval);
         hold_and_clear($unsigned($random(seed)) % 4 + 1);
      end
   endtask

   task automatic run_boundaries();
      board_t b;
      int     r;
      b = '0;
      run_board(b, 0, 0);                     // Empty board
      repeat (2)
      begin
         for (int sq = 0; sq < `SQUARES; sq++)
         begin
            r = $random(seed);
            b[sq * `PIECE_WIDTH +: `PIECE_WIDTH] = {r[3], 3'(r[15:8] % 6 + 1)};
         end
         run_board(b, 3, full_phase_eval(b)); // All 64 occupied
      end
      b[0 +: `PIECE_WIDTH] = 4'h0;            // 63 pieces, still clamped
      run_board(b, 1, full_phase_eval(b));
      for (int k = 0; k < 2; k++)
      begin
         for (int sq = 0; sq < `SQUARES; sq++)
         begin
            r = $random(seed);
            b[sq * `PIECE_WIDTH +: `PIECE_WIDTH] = {r[3], (r[0] || k == 1) ? 3'd6 : 3'd0};
         end
         run_board(b, 2, 0);                  // Kings only
      end
   endtask

   // board_valid held high through clear must not restart
   task automatic hold_across_clear();
      board_t first;
      board_t stale;
      board_t fresh;
      logic   seen;
      make_random_board(first);
      make_random_board(stale);
      make_random_board(fresh);
      @(posedge clk);
      board_in          <= first;
      board_valid       <= 1'b1;
      is_attacking_done <= 1'b1;
      wait_for_valid(seen);
      if (seen)
         check_result(first, expected_eval(first));
      board_in <= stale;
      hold_and_clear(1);
      is_attacking_done <= 1'b1;
      repeat (25)
      begin
         @(posedge clk);
         assert (!eval_valid)
         else
         begin
            protocol_errors++;
            $display("a board_valid held high started a new evaluation");
         end
      end
      board_valid <= 1'b0;
      @(posedge clk);
      board_in    <= fresh;
      board_valid <= 1'b1;
      @(posedge clk);
      board_valid <= 1'b0;
      board_in    <= stale;
      wait_for_valid(seen);
      if (seen)
      begin
         check_result(fresh, expected_eval(fresh));
         hold_and_clear(2);
      end
   endtask

   initial
   begin
      while (cycle_count < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
      $display("errors: value %0d, protocol %0d", value_errors, protocol_errors);
      $display("sim failed");
      $finish;
   end

   initial
   begin
      board_t b;
      reset             <= 1'b1;
      board_valid       <= 1'b0;
      board_in          <= '0;
      is_attacking_done <= 1'b0;
      clear_eval        <= 1'b0;
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      assert (!eval_valid)
      else
      begin
         protocol_errors++;
         $display("eval_valid was high right after reset");
      end
      for (int n = 0; n < NUM_BOARDS; n++)
      begin
         make_random_board(b);
         run_board(b, $unsigned($random(seed)) % 21, expected_eval(b));
      end
      run_boundaries();
      hold_across_clear();
      $display("errors: value %0d, protocol %0d", value_errors, protocol_errors);
      if (value_errors == 0 && protocol_errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: hw/evaluate_top.sv
`default_nettype none

`include "eval_params.svh"

module evaluate_top (
   input  logic                clk,
   input  logic                reset,
   input  logic                board_valid,
   input  eval_pkg::board_t    board_in,
   input  logic                is_attacking_done,
   input  logic                clear_eval,
   output eval_pkg::score_t    eval,
   output logic                eval_valid,
   output eval_pkg::material_t material_white,
   output eval_pkg::material_t material_black
);
   import eval_pkg::*;

   board_t board;                             // Captured copy
   logic   start;
   logic   material_done;
   logic   phase_done;
   score_t score_mg;
   score_t score_eg;
   phase_t phase;

   eval_control eval_control_i (
      .clk               (clk),
      .reset             (reset),
      .board_valid       (board_valid),
      .board_in          (board_in),
      .is_attacking_done (is_attacking_done),
      .clear_eval        (clear_eval),
      .material_done     (material_done),
      .phase_done        (phase_done),
      .board             (board),
      .start             (start),
      .eval_valid        (eval_valid)
   );

   material_eval material_eval_i (
      .clk            (clk),
      .reset          (reset),
      .start          (start),
      .clear_eval     (clear_eval),
      .board          (board),
      .score_mg       (score_mg),
      .score_eg       (score_eg),
      .material_white (material_white),
      .material_black (material_black),
      .material_done  (material_done)
   );

   occupancy_phase occupancy_phase_i (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .clear_eval (clear_eval),
      .board      (board),
      .phase      (phase),
      .phase_done (phase_done)
   );

   taper_blend taper_blend_i (               // Runs every cycle
      .clk      (clk),
      .score_mg (score_mg),
      .score_eg (score_eg),
      .phase    (phase),
      .eval     (eval)
   );

endmodule

`default_nettype wire

// File: evaluate/taper_blend.sv
`default_nettype none

`include "eval_params.svh"

module taper_blend (
   input  logic             clk,
   input  eval_pkg::score_t score_mg,
   input  eval_pkg::score_t score_eg,
   input  eval_pkg::phase_t phase,
   output eval_pkg::score_t eval
);
   import eval_pkg::*;

   localparam blend_t SCALE_DIV = blend_t'(1) <<< `PHASE_SCALE_SHIFT; // Fixed-point unit

   phase_t eg_weight;                         // Share of the end-game score
   blend_t mg_part;
   blend_t eg_part;
   blend_t blend_sum;
   blend_t blend_scaled;

   assign eg_weight = phase_t'(`PHASE_MAX) - phase;

   // Result = (mg * phase + eg * (62 - phase)) / 62 in fixed point
   always_ff @(posedge clk)
   begin
      mg_part      <= blend_t'(score_mg) * blend_t'(phase);       // Stage 1 with phase zero-extended
      eg_part      <= blend_t'(score_eg) * blend_t'(eg_weight);
      blend_sum    <= mg_part + eg_part;                          // Stage 2
      blend_scaled <= blend_sum * blend_t'(`PHASE_RECIP);         // Stage 3
      eval         <= score_t'(blend_scaled / SCALE_DIV);         // Stage 4 rounds toward zero
   end

endmodule

`default_nettype wire

// File: evaluate/occupancy_phase.sv
`default_nettype none

`include "eval_params.svh"

module occupancy_phase (
   input  logic             clk,
   input  logic             reset,
   input  logic             start,
   input  logic             clear_eval,
   input  eval_pkg::board_t board,
   output eval_pkg::phase_t phase,
   output logic             phase_done
);
   import eval_pkg::*;

   logic [`SQUARES-1:0] occupied;             // One bit per square
   piece_t              sq_piece;
   occ_count_t          popcount;
   occ_count_t          occ_count;            // Registered on start
   logic                count_valid;

   always_comb
   begin
      occupied = '0;
      popcount = '0;
      sq_piece = '0;
      for (int sq = 0; sq < `SQUARES; sq++)
      begin
         sq_piece = board[sq * `PIECE_WIDTH +: `PIECE_WIDTH];
         occupied[sq] = (sq_piece[2:0] != `PIECE_EMPTY) &&
                        (sq_piece[2:0] != `PIECE_UNUSED);
      end
      for (int sq = 0; sq < `SQUARES; sq++)
         popcount = popcount + occ_count_t'(occupied[sq]);
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         count_valid <= 1'b0;
         phase_done  <= 1'b0;
      end
      else
      begin
         count_valid <= start;
         if (count_valid)
            phase_done <= 1'b1;               // Held until the result is consumed
         else if (clear_eval)
            phase_done <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
         occ_count <= popcount;
      if (count_valid)
         phase <= (occ_count > `PHASE_MAX) ? phase_t'(`PHASE_MAX)
                                           : phase_t'(occ_count); // Clamp 63 and 64
   end

endmodule

`default_nettype wire

// File: evaluate/material_eval.sv
`default_nettype none

`include "eval_params.svh"

module material_eval (
   input  logic                clk,
   input  logic                reset,
   input  logic                start,
   input  logic                clear_eval,
   input  eval_pkg::board_t    board,
   output eval_pkg::score_t    score_mg,
   output eval_pkg::score_t    score_eg,
   output eval_pkg::material_t material_white,
   output eval_pkg::material_t material_black,
   output logic                material_done
);
   import eval_pkg::*;

   localparam int FILES = `SQUARES / `RANKS;  // Squares per rank

   logic [2:0] rank;                          // Rank being summed, idles at 0
   logic       scanning;
   logic       scan_last;                     // Final rank went in last cycle
   piece_t     piece;
   material_t  rank_mg_white;
   material_t  rank_mg_black;
   material_t  rank_eg_white;
   material_t  rank_eg_black;
   material_t  acc_mg_white;
   material_t  acc_mg_black;
   material_t  acc_eg_white;
   material_t  acc_eg_black;

   function automatic material_t mg_value(input piece_t p);
      case (p[2:0])
         `PIECE_PAWN:   mg_value = `MG_PAWN;
         `PIECE_KNIGHT: mg_value = `MG_KNIGHT;
         `PIECE_BISHOP: mg_value = `MG_BISHOP;
         `PIECE_ROOK:   mg_value = `MG_ROOK;
         `PIECE_QUEEN:  mg_value = `MG_QUEEN;
         `PIECE_KING:   mg_value = '0;
         default:       mg_value = '0;    // Empty or unused code
      endcase
   endfunction

   function automatic material_t eg_value(input piece_t p);
      case (p[2:0])
         `PIECE_PAWN:   eg_value = `EG_PAWN;
         `PIECE_KNIGHT: eg_value = `EG_KNIGHT;
         `PIECE_BISHOP: eg_value = `EG_BISHOP;
         `PIECE_ROOK:   eg_value = `EG_ROOK;
         `PIECE_QUEEN:  eg_value = `EG_QUEEN;
         default:       eg_value = '0;
      endcase
   endfunction

   // Sum the eight squares of the current rank per side
   always_comb
   begin
      rank_mg_white = '0;
      rank_mg_black = '0;
      rank_eg_white = '0;
      rank_eg_black = '0;
      piece         = '0;
      for (int f = 0; f < FILES; f++)
      begin
         piece = board[(rank * FILES + f) * `PIECE_WIDTH +: `PIECE_WIDTH];
         if (piece[`PIECE_BLACK_BIT])
         begin
            rank_mg_black = rank_mg_black + mg_value(piece);
            rank_eg_black = rank_eg_black + eg_value(piece);
         end
         else
         begin
            rank_mg_white = rank_mg_white + mg_value(piece);
            rank_eg_white = rank_eg_white + eg_value(piece);
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rank          <= '0;
         scanning      <= 1'b0;
         scan_last     <= 1'b0;
         material_done <= 1'b0;
      end
      else
      begin
         scan_last <= 1'b0;
         if (start)
            scanning <= 1'b1;                 // Rank 0 is summed on the start cycle
         if (start || scanning)
         begin
            rank <= rank + 1'b1;              // Wraps back to 0 after rank 7
            if (rank == 3'(`RANKS - 1))
            begin
               scanning  <= 1'b0;
               scan_last <= 1'b1;
            end
         end
         if (scan_last)
            material_done <= 1'b1;
         else if (clear_eval)
            material_done <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         acc_mg_white <= rank_mg_white;       // Fresh board, drop old totals
         acc_mg_black <= rank_mg_black;
         acc_eg_white <= rank_eg_white;
         acc_eg_black <= rank_eg_black;
      end
      else if (scanning)
      begin
         acc_mg_white <= acc_mg_white + rank_mg_white;
         acc_mg_black <= acc_mg_black + rank_mg_black;
         acc_eg_white <= acc_eg_white + rank_eg_white;
         acc_eg_black <= acc_eg_black + rank_eg_black;
      end
      if (scan_last)
      begin
         score_mg       <= score_t'(acc_mg_white - acc_mg_black); // Wraps to signed
         score_eg       <= score_t'(acc_eg_white - acc_eg_black);
         material_white <= acc_mg_white;
         material_black <= acc_mg_black;
      end
   end

endmodule

`default_nettype wire

// File: hw/eval_control.sv
`default_nettype none

`include "eval_params.svh"

module eval_control (
   input  logic             clk,
   input  logic             reset,
   input  logic             board_valid,
   input  eval_pkg::board_t board_in,
   input  logic             is_attacking_done,
   input  logic             clear_eval,
   input  logic             material_done,
   input  logic             phase_done,
   output eval_pkg::board_t board,
   output logic             start,
   output logic             eval_valid
);
   import eval_pkg::*;

   eval_state_t state;
   logic        board_valid_r;                // Previous board_valid for edge detect
   logic        board_edge;
   logic [2:0]  latency;                      // Blend pipeline wait

   assign board_edge = board_valid && !board_valid_r; // Low to high only

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= eval_idle;
         board_valid_r <= 1'b0;
         start         <= 1'b0;
         eval_valid    <= 1'b0;
         latency       <= '0;
      end
      else
      begin
         board_valid_r <= board_valid;        // Tracks in every state
         start         <= 1'b0;               // Single-cycle pulse
         case (state)
            eval_idle:
               if (board_edge)
                  state <= eval_wait_attacking_done;
            eval_wait_attacking_done:
               if (is_attacking_done)
               begin
                  start <= 1'b1;              // Kick both terms
                  state <= eval_wait_terms;
               end
            eval_wait_terms:
               if (material_done && phase_done)
               begin
                  latency <= '0;
                  state   <= eval_wait_latency;
               end
            eval_wait_latency:
            begin
               latency <= latency + 1'b1;
               if (latency == 3'(`LATENCY_COUNT - 1))
               begin
                  eval_valid <= 1'b1;         // Blend output has settled
                  state      <= eval_wait_clear;
               end
            end
            eval_wait_clear:
               if (clear_eval)
               begin
                  eval_valid <= 1'b0;
                  state      <= eval_idle;
               end
            default:
               state <= eval_idle;
         endcase
      end
   end

   // Board snapshot taken at the accepted edge only
   always_ff @(posedge clk)
   begin
      if (state == eval_idle && board_edge)
         board <= board_in;
   end

endmodule

`default_nettype wire

// File: common/eval_pkg.sv
`default_nettype none

`include "eval_params.svh"

package eval_pkg;

   typedef logic [`PIECE_WIDTH-1:0] piece_t;           // One square
   typedef logic [`BOARD_WIDTH-1:0] board_t;           // Whole board, rank by rank
   typedef logic signed [`EVAL_WIDTH-1:0] score_t;     // Positive favours white
   typedef logic [31:0] material_t;                    // Per-side total
   typedef logic [5:0] phase_t;                        // 0 to 62
   typedef logic [6:0] occ_count_t;                    // 0 to 64 pieces
   typedef logic signed [`BLEND_WIDTH-1:0] blend_t;    // Taper intermediate

   // Controller sequence for one board
   typedef enum logic [2:0] {
      eval_idle,
      eval_wait_attacking_done,
      eval_wait_terms,
      eval_wait_latency,
      eval_wait_clear
   } eval_state_t;

endpackage

`default_nettype wire

// File: common/eval_params.svh
`ifndef EVAL_PARAMS_SVH
`define EVAL_PARAMS_SVH

// Board geometry
`define SQUARES           64
`define RANKS             8
`define PIECE_WIDTH       4          // Colour bit over a 3-bit type
`define BOARD_WIDTH       256        // Square 0 in the low nibble

// Square encoding
`define PIECE_BLACK_BIT   3
`define PIECE_EMPTY       3'd0
`define PIECE_PAWN        3'd1
`define PIECE_KNIGHT      3'd2
`define PIECE_BISHOP      3'd3
`define PIECE_ROOK        3'd4
`define PIECE_QUEEN       3'd5
`define PIECE_KING        3'd6
`define PIECE_UNUSED      3'd7       // Reads as an empty square

// Score and phase arithmetic
`define EVAL_WIDTH        24
`define PHASE_MAX         62
`define PHASE_SCALE_SHIFT 20
`define PHASE_RECIP       16912      // 2^20 / 62, truncated
`define BLEND_WIDTH       48
`define LATENCY_COUNT     5          // Blend pipeline settle time

// Piece values, middle game then end game
`define MG_PAWN           82
`define MG_KNIGHT         337
`define MG_BISHOP         365
`define MG_ROOK           477
`define MG_QUEEN          1025
`define EG_PAWN           94
`define EG_KNIGHT         281
`define EG_BISHOP         297
`define EG_ROOK           512
`define EG_QUEEN          936

`endif
